// File: Makefile
TOP := tb_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/icache_model.sv
// icache model: behavioral instruction cache answering each request after a random delay
`timescale 1ns/1ps
`default_nettype none

module icache_model (
   input  logic             CLK,
   input  logic             rst_n,
   input  logic             icache_en,
   input  fetch_pkg::addr_t icache_addr,
   output fetch_pkg::line_t icache_rd_data,
   output logic             icache_ready
);
   import fetch_pkg::*;

   logic  busy;
   addr_t req_addr;
   int    wait_left;

   // byte at linear address A is A[7:0] xor A[15:8]
   function automatic line_t line_bytes(addr_t base);
      line_t data;
      addr_t a;
      for (int i = 0; i < LINE_BYTES; i++) begin
         a = base + addr_t'(i);
         data[i*8 +: 8] = a[7:0] ^ a[15:8];
      end
      return data;
   endfunction

   // request tracking, a dropped enable aborts the open request
   always @(posedge CLK) begin
      if (!rst_n || !icache_en) begin
         busy <= 1'b0;
      end else if (busy && icache_ready) begin
         busy <= 1'b0;
      end else if (!busy) begin
         busy      <= 1'b1;
         req_addr  <= icache_addr;
         wait_left <= int'($urandom % 4);
      end else if (wait_left > 0) begin
         wait_left <= wait_left - 1;
      end
   end

   // outputs change on the falling edge
   initial begin
      icache_ready   = 1'b0;
      icache_rd_data = '0;
      forever begin
         @(negedge CLK);
         icache_ready   <= busy && (wait_left == 0);
         icache_rd_data <= line_bytes(req_addr);
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_fetch.sv
// fetch testbench running directed tests of the front end against a behavioral cache
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;
   import fetch_pkg::*;

   localparam int NUM_SLOTS  = 4;
   localparam int WAIT_LIMIT = 200;

   logic  CLK;
   logic  rst_n;
   logic  flush;
   logic  icache_ready;
   logic  icache_en;
   logic  ir_valid;
   logic  dep_stall;
   addr_t eip;
   addr_t icache_addr;
   addr_t eip_out;
   seg_t  cs;
   len_t  instr_len;
   line_t icache_rd_data;
   line_t ir;

   // reference decoder position since the last redirect
   addr_t exp_eip;
   seg_t  cur_cs;
   int    consumed;
   int    req_count;
   int    checks;
   int    errors;

   fetch_top #(.NUM_SLOTS(NUM_SLOTS)) i_dut (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .eip            (eip),
      .cs             (cs),
      .flush          (flush),
      .icache_rd_data (icache_rd_data),
      .icache_ready   (icache_ready),
      .instr_len      (instr_len),
      .dep_stall      (dep_stall),
      .icache_addr    (icache_addr),
      .icache_en      (icache_en),
      .ir             (ir),
      .eip_out        (eip_out),
      .ir_valid       (ir_valid)
   );

   icache_model i_cache (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .icache_en      (icache_en),
      .icache_addr    (icache_addr),
      .icache_rd_data (icache_rd_data),
      .icache_ready   (icache_ready)
   );

   initial begin
      CLK = 1'b0;
      forever begin
         #5 CLK = ~CLK;
      end
   end

   // cache handshakes since the last redirect
   always @(posedge CLK) begin
      if (!rst_n || flush) begin
         req_count <= 0;
      end else if (icache_en && icache_ready) begin
         req_count <= req_count + 1;
      end
   end

   // 16 bytes from the xor address pattern
   function automatic line_t window_at(addr_t lin);
      line_t w;
      addr_t a;
      for (int i = 0; i < LINE_BYTES; i++) begin
         a = lin + addr_t'(i);
         w[i*8 +: 8] = a[7:0] ^ a[15:8];
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got %0h, expected %0h", name, got, exp);
      end
   endtask

   // wait for a valid window, or for a cache request when want_window is low
   task automatic wait_for(input bit want_window, output bit ok);
      int cycles;
      cycles = 0;
      while (((want_window ? ir_valid : icache_en) !== 1'b1) && cycles < WAIT_LIMIT) begin
         @(negedge CLK);
         cycles++;
      end
      ok = ((want_window ? ir_valid : icache_en) === 1'b1);
      if (!ok) begin
         errors++;
         $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT,
                  want_window ? "a valid window" : "a cache request");
      end
   endtask

   // one flush cycle with a new cs:eip
   task automatic redirect(input addr_t new_eip, input seg_t new_cs);
      eip   = new_eip;
      cs    = new_cs;
      flush = 1'b1;
      @(negedge CLK);
      flush    = 1'b0;
      exp_eip  = new_eip;
      cur_cs   = new_cs;
      consumed = 0;
   endtask

   task automatic consume_run(input int count);
      bit   ok;
      len_t len;
      ok = 1'b1;
      for (int n = 0; n < count && ok; n++) begin
         wait_for(1'b1, ok);
         if (ok) begin
            len = len_t'(1 + $urandom % 15);
            check_value("eip_out", 128'(eip_out), 128'(exp_eip));
            check_value("ir", ir, window_at(addr_t'(cur_cs) * 32'd65536 + exp_eip));
            instr_len = len;
            dep_stall = 1'b0;
            @(negedge CLK);
            dep_stall = 1'b1;
            exp_eip   = exp_eip + addr_t'(len);
            consumed  = consumed + int'(len);
            check_value("eip_out", 128'(eip_out), 128'(exp_eip));
         end
      end
   endtask

   task automatic reset_state_check();
      bit ok;
      repeat (5) begin
         @(negedge CLK);
         check_value("icache_en", 128'(icache_en), 128'(0));
         check_value("ir_valid", 128'(ir_valid), 128'(0));
      end
      rst_n = 1'b1;
      wait_for(1'b0, ok);
      if (ok) begin
         check_value("icache_addr", 128'(icache_addr), 128'(addr_t'(cs) * 32'd65536 + eip));
      end
      check_value("eip_out", 128'(eip_out), 128'(eip));
   endtask

   task automatic sequential_consume();
      consume_run(60);
   endtask

   task automatic stall_hold();
      bit    ok;
      line_t held_ir;
      addr_t held_eip;
      wait_for(1'b1, ok);
      if (!ok) begin
         return;
      end
      held_ir  = ir;
      held_eip = eip_out;
      repeat (40) begin
         instr_len = len_t'(1 + $urandom % 15);
         @(negedge CLK);
         check_value("ir", ir, held_ir);
         check_value("eip_out", 128'(eip_out), 128'(held_eip));
         // requests bounded by ring depth plus released slots
         check_value("req_count bound", 128'(req_count <= NUM_SLOTS + consumed / 16), 128'(1));
      end
      check_value("icache_en", 128'(icache_en), 128'(0));
      consume_run(10);
   endtask

   task automatic redirect_fetch();
      bit ok;
      redirect(32'h0000_7ff5, 16'h0f00);
      check_value("eip_out", 128'(eip_out), 128'(exp_eip));
      check_value("ir_valid", 128'(ir_valid), 128'(0));
      wait_for(1'b0, ok);
      if (ok) begin
         check_value("icache_addr", 128'(icache_addr), 128'(32'h0f00_7ff5));
      end
      consume_run(30);
   endtask

   task automatic flush_mid_request();
      bit ok;
      redirect(32'h0000_2040, 16'h0001);
      wait_for(1'b0, ok);
      if (!ok) begin
         return;
      end
      // cache has taken the request by now
      @(negedge CLK);
      check_value("icache_en", 128'(icache_en), 128'(1));
      redirect(32'h0000_abcd, 16'h1234);
      wait_for(1'b0, ok);
      if (ok) begin
         check_value("icache_addr", 128'(icache_addr), 128'(32'h1234_abcd));
      end
      consume_run(25);
   endtask

   initial begin
      void'($urandom(32'hb90e));
      rst_n     = 1'b0;
      flush     = 1'b0;
      eip       = 32'h0000_1003;
      cs        = 16'h0010;
      instr_len = len_t'(1);
      dep_stall = 1'b1;
      checks    = 0;
      errors    = 0;
      exp_eip   = eip;
      cur_cs    = cs;
      consumed  = 0;
      reset_state_check();
      sequential_consume();
      stall_hold();
      redirect_fetch();
      flush_mid_request();
      @(negedge CLK);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
hdl/fetch_pkg.sv
hdl/line_fill_if.sv
hdl/window_if.sv
hdl/byte_aligner.sv
hdl/icache_requester.sv
hdl/line_buffer.sv
hdl/window_reader.sv
hdl/fetch_top.sv
dv/icache_model.sv
dv/tb_fetch.sv

// File: hdl/byte_aligner.sv
// byte aligner: 16-byte window starting at any offset across two adjacent lines
`timescale 1ns/1ps
`default_nettype none

module byte_aligner (
   input  fetch_pkg::line_t line_lo,
   input  fetch_pkg::line_t line_hi,
   input  fetch_pkg::off_t  offset,
   output fetch_pkg::line_t window
);
   import fetch_pkg::*;

   // both lines as one byte array, line_lo byte 0 at index 0
   logic [2*LINE_BYTES-1:0][7:0] pair;

   assign pair = {line_hi, line_lo};

   always_comb begin
      int src;
      for (int i = 0; i < LINE_BYTES; i++) begin
         // never past index 30 since offset is at most 15
         src = int'(offset) + i;
         window[i*8 +: 8] = pair[src];
      end
   end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
// fetch_pkg: line, address and length types shared across the instruction fetch unit
`default_nettype none

package fetch_pkg;

   // one cache line, and one decode window, in bytes
   localparam int LINE_BYTES = 16;

   // 128-bit line or window, byte 0 in bits [7:0]
   typedef logic [LINE_BYTES*8-1:0] line_t;

   // linear address or EIP
   typedef logic [31:0] addr_t;

   // code segment selector
   typedef logic [15:0] seg_t;

   // instruction length from the decoder, 1 to 15
   typedef logic [3:0] len_t;

   // byte offset inside a line
   typedef logic [$clog2(LINE_BYTES)-1:0] off_t;

endpackage

`default_nettype wire

// File: hdl/fetch_top.sv
// fetch top: instruction fetch front end from cache request to decode window
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
   parameter int NUM_SLOTS = 4
) (
   input  logic             CLK,
   input  logic             rst_n,
   input  fetch_pkg::addr_t eip,
   input  fetch_pkg::seg_t  cs,
   input  logic             flush,
   input  fetch_pkg::line_t icache_rd_data,
   input  logic             icache_ready,
   input  fetch_pkg::len_t  instr_len,
   input  logic             dep_stall,
   output fetch_pkg::addr_t icache_addr,
   output logic             icache_en,
   output fetch_pkg::line_t ir,
   output fetch_pkg::addr_t eip_out,
   output logic             ir_valid
);

   // requester to ring
   line_fill_if #(.NUM_SLOTS(NUM_SLOTS)) fill_bus ();

   // ring to reader
   window_if #(.NUM_SLOTS(NUM_SLOTS)) win_bus ();

   icache_requester #(
      .NUM_SLOTS (NUM_SLOTS)
   ) i_requester (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .flush          (flush),
      .eip            (eip),
      .cs             (cs),
      .icache_ready   (icache_ready),
      .icache_rd_data (icache_rd_data),
      .icache_addr    (icache_addr),
      .icache_en      (icache_en),
      .fill           (fill_bus.requester)
   );

   line_buffer #(
      .NUM_SLOTS (NUM_SLOTS)
   ) i_buffer (
      .CLK   (CLK),
      .rst_n (rst_n),
      .flush (flush),
      .fill  (fill_bus.buffer),
      .win   (win_bus.buffer)
   );

   window_reader #(
      .NUM_SLOTS (NUM_SLOTS)
   ) i_reader (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .flush     (flush),
      .eip       (eip),
      .instr_len (instr_len),
      .dep_stall (dep_stall),
      .win       (win_bus.reader),
      .ir        (ir),
      .eip_out   (eip_out),
      .ir_valid  (ir_valid)
   );

endmodule

`default_nettype wire

// File: hdl/icache_requester.sv
// icache requester: fetch pointer, credit count and cache enable/ready handshake
`timescale 1ns/1ps
`default_nettype none

module icache_requester #(
   parameter int NUM_SLOTS = 4
) (
   input  logic             CLK,
   input  logic             rst_n,
   input  logic             flush,
   input  fetch_pkg::addr_t eip,
   input  fetch_pkg::seg_t  cs,
   input  logic             icache_ready,
   input  fetch_pkg::line_t icache_rd_data,
   output fetch_pkg::addr_t icache_addr,
   output logic             icache_en,
   line_fill_if.requester   fill
);
   import fetch_pkg::*;

   localparam int CRED_W = $clog2(NUM_SLOTS + 1);

   addr_t             fetch_ptr;
   addr_t             redirect_addr;
   logic [CRED_W-1:0] credits;
   logic [CRED_W-1:0] credits_nxt;
   logic              running;
   logic              send;

   // linear address = cs * 64K + eip
   assign redirect_addr = eip + addr_t'({cs, 16'h0000});

   // request while credits remain, never in a flush cycle
   assign icache_en   = running && (credits != '0) && !flush;
   assign icache_addr = fetch_ptr;
   assign send        = icache_en && icache_ready;

   // the line goes into the ring on the same edge the cache answers
   assign fill.fill_valid = send;
   assign fill.fill_line  = icache_rd_data;

   always_comb begin
      credits_nxt = credits;
      if (send) begin
         credits_nxt = credits_nxt - CRED_W'(1);
      end
      if (fill.credit_return) begin
         credits_nxt = credits_nxt + CRED_W'(1);
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n || flush) begin
         // redirect: restart from cs:eip with a full set of credits
         running   <= rst_n;
         credits   <= CRED_W'(NUM_SLOTS);
         fetch_ptr <= redirect_addr;
      end else begin
         running <= 1'b1;
         credits <= credits_nxt;
         if (send) begin
            fetch_ptr <= fetch_ptr + addr_t'(LINE_BYTES);
         end
      end
   end

   // an open request keeps its address until the cache answers
   a_addr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
      icache_en && !icache_ready |=> icache_addr == $past(icache_addr));

   // ring releases never return more credits than were spent
   a_credit_max: assert property (@(posedge CLK) disable iff (!rst_n)
      credits <= CRED_W'(NUM_SLOTS));

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
// line buffer: ring of fetched lines with write pointer, occupancy and credit return
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
   parameter int NUM_SLOTS = 4
) (
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        flush,
   line_fill_if.buffer fill,
   window_if.buffer    win
);
   import fetch_pkg::*;

   localparam int SLOT_W = $clog2(NUM_SLOTS);
   localparam int HELD_W = $clog2(NUM_SLOTS + 1);

   line_t             slots [NUM_SLOTS];
   logic [SLOT_W-1:0] wr_ptr;
   logic [SLOT_W-1:0] hi_slot;
   logic [HELD_W-1:0] held;

   // line storage
   always_ff @(posedge CLK) begin
      if (fill.fill_valid) begin
         slots[wr_ptr] <= fill.fill_line;
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n || flush) begin
         wr_ptr             <= '0;
         held               <= '0;
         fill.credit_return <= 1'b0;
      end else begin
         if (fill.fill_valid) begin
            wr_ptr <= wr_ptr + SLOT_W'(1);
         end
         held <= held + HELD_W'(fill.fill_valid) - HELD_W'(win.slot_release);
         // freed slot goes back as a credit one cycle later
         fill.credit_return <= win.slot_release;
      end
   end

   // next slot wraps since depth is a power of two
   assign hi_slot = win.rd_slot + SLOT_W'(1);

   assign win.line_lo    = slots[win.rd_slot];
   assign win.line_hi    = slots[hi_slot];
   assign win.lines_held = held;

   // requester must run out of credits before the ring overflows
   a_no_overfill: assert property (@(posedge CLK) disable iff (!rst_n)
      fill.fill_valid |-> held != HELD_W'(NUM_SLOTS));

endmodule

`default_nettype wire

// File: hdl/line_fill_if.sv
// line fill interface: lines from the cache requester into the ring, credits back
`timescale 1ns/1ps
`default_nettype none

interface line_fill_if #(
   parameter int NUM_SLOTS = 4
);
   import fetch_pkg::*;

   logic  fill_valid;
   line_t fill_line;
   logic  credit_return;

   // ring depth must be a power of two, two or more
   if (NUM_SLOTS < 2 || (NUM_SLOTS & (NUM_SLOTS - 1)) != 0) begin : g_bad_depth
      $error("line_fill_if: NUM_SLOTS must be a power of two, 2 or more");
   end

   modport requester (
      output fill_valid,
      output fill_line,
      input  credit_return
   );

   modport buffer (
      input  fill_valid,
      input  fill_line,
      output credit_return
   );

endinterface

`default_nettype wire

// File: hdl/window_if.sv
// window interface: slot select, adjacent lines and slot release between ring and reader
`timescale 1ns/1ps
`default_nettype none

interface window_if #(
   parameter int NUM_SLOTS = 4
);
   import fetch_pkg::*;

   localparam int SLOT_W = $clog2(NUM_SLOTS);
   localparam int HELD_W = $clog2(NUM_SLOTS + 1);

   logic [SLOT_W-1:0] rd_slot;
   logic              slot_release;
   line_t             line_lo;
   line_t             line_hi;
   logic [HELD_W-1:0] lines_held;

   modport buffer (
      input  rd_slot,
      input  slot_release,
      output line_lo,
      output line_hi,
      output lines_held
   );

   modport reader (
      output rd_slot,
      output slot_release,
      input  line_lo,
      input  line_hi,
      input  lines_held
   );

endinterface

`default_nettype wire

// File: hdl/window_reader.sv
// window reader: read pointer, EIP tracking and decode window valid
`timescale 1ns/1ps
`default_nettype none

module window_reader #(
   parameter int NUM_SLOTS = 4
) (
   input  logic             CLK,
   input  logic             rst_n,
   input  logic             flush,
   input  fetch_pkg::addr_t eip,
   input  fetch_pkg::len_t  instr_len,
   input  logic             dep_stall,
   window_if.reader         win,
   output fetch_pkg::line_t ir,
   output fetch_pkg::addr_t eip_out,
   output logic             ir_valid
);
   import fetch_pkg::*;

   localparam int SLOT_W = $clog2(NUM_SLOTS);
   localparam int HELD_W = $clog2(NUM_SLOTS + 1);
   localparam int OFF_W  = $bits(off_t);

   logic [SLOT_W-1:0] rd_slot;
   off_t              offset;
   logic [OFF_W:0]    off_sum;
   logic              consume;
   logic              wrap;

   // aligned start needs one line, otherwise the window spills into the next
   assign ir_valid = (win.lines_held >= HELD_W'(2)) ||
                     ((win.lines_held != '0) && (offset == '0));

   assign consume = ir_valid && !dep_stall;

   // carry out of the offset means the low line is used up
   assign off_sum = {1'b0, offset} + {1'b0, instr_len};
   assign wrap    = off_sum[OFF_W];

   assign win.rd_slot      = rd_slot;
   assign win.slot_release = consume && wrap;

   always_ff @(posedge CLK) begin
      if (!rst_n || flush) begin
         rd_slot <= '0;
         offset  <= '0;
         eip_out <= eip;
      end else if (consume) begin
         rd_slot <= rd_slot + SLOT_W'(wrap);
         offset  <= off_sum[OFF_W-1:0];
         eip_out <= eip_out + addr_t'(instr_len);
      end
   end

   byte_aligner i_aligner (
      .line_lo (win.line_lo),
      .line_hi (win.line_hi),
      .offset  (offset),
      .window  (ir)
   );

   // decoder must always report a real length
   a_len_nonzero: assert property (@(posedge CLK) disable iff (!rst_n)
      consume |-> instr_len != '0);

endmodule

`default_nettype wire
